// File: vlog.f
source/commu_pkg.sv
source/commu_head.sv
source/commu_data.sv
source/commu_tail.sv
source/commu_main.sv
source/commu_tx.sv
source/commu_top.sv
dv/commu_assertions.sv
dv/commu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the commu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module commu_tb -f vlog.f -o commu_sim \
	|| { echo "build failed"; exit 1; }

out="$(./obj_dir/commu_sim)"
echo "$out"
echo "$out" | grep -qx "No errors" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: dv/commu_tb.sv
// testbench for commu_top, runs a table of frames and decodes tx_line back into words
`timescale 1ns/1ps

module commu_tb;
	import commu_pkg::*;

	localparam int N_ROWS = 5;
	localparam int FRAME_LEN = 1 + int'(PAYLOAD_WORDS) + int'(TAIL_WORDS);
	localparam int WATCH_CYCLES = N_ROWS * (FRAME_LEN * 40 + 2 * int'(TX_TIMEOUT));

	logic clk_sys;
	logic rst_n;
	logic frame_start;
	logic busy;
	logic frame_done;
	logic payload_valid;
	logic payload_ready;
	logic [15:0] payload_word;
	logic cts;
	logic tx_line;
	logic [7:0] drop_cnt;

	// stimulus table with one row per frame
	// a payload word of 0 takes the next LFSR word
	logic [15:0] tab_words [N_ROWS][4];
	int tab_stall [N_ROWS];
	int tab_len [N_ROWS];
	int tab_delay [N_ROWS];

	logic [31:0] lfsr_q;
	logic [15:0] pay_words [4];
	int pay_idx;
	int pay_wait;
	int pay_delay;
	bit ready_check;
	int stall_k;
	int stall_len;
	int cts_hold;
	int dec_state;
	int dec_bits;
	int dec_count;
	logic [15:0] dec_shift;
	logic [15:0] rx_words [$];
	int done_count;
	int errors;

	commu_top DUT (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.frame_start(frame_start),
		.busy(busy),
		.frame_done(frame_done),
		.payload_valid(payload_valid),
		.payload_ready(payload_ready),
		.payload_word(payload_word),
		.cts(cts),
		.tx_line(tx_line),
		.drop_cnt(drop_cnt)
	);

	bind commu_top commu_assertions u_assertions (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.fire_head(u_main.fire_head),
		.fire_data(u_main.fire_data),
		.fire_tail(u_main.fire_tail),
		.word_fire_head(u_main.word_fire_head),
		.word_fire_data(u_main.word_fire_data),
		.word_fire_tail(u_main.word_fire_tail),
		.tx_fire(u_main.tx_fire),
		.tx_abort(u_main.tx_abort),
		.st_tx(u_tx.st_tx),
		.tx_line(tx_line)
	);

	always #10 clk_sys = ~clk_sys;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	task automatic random_word(output logic [15:0] w);
		w = '0;
		for (int i = 0; i < 16; i++) begin
			w = {w[14:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic load_table();
		// clean frame, no stall
		tab_words[0] = '{16'h1234, 16'habcd, 16'h0f0f, 16'h8001};
		tab_stall[0] = -1;
		tab_len[0] = 0;
		tab_delay[0] = 0;
		// random payload, slow source
		tab_words[1] = '{16'h0, 16'h0, 16'h0, 16'h0};
		tab_stall[1] = -1;
		tab_len[1] = 0;
		tab_delay[1] = 3;
		// long stall after payload 1 drops payload 2
		tab_words[2] = '{16'h5a5a, 16'h0001, 16'hc3c3, 16'h7ffe};
		tab_stall[2] = 2;
		tab_len[2] = 2 * int'(TX_TIMEOUT);
		tab_delay[2] = 1;
		// short stall after the head word only delays
		tab_words[3] = '{16'h0, 16'h0, 16'h0, 16'h0};
		tab_stall[3] = 0;
		tab_len[3] = int'(TX_TIMEOUT) / 2;
		tab_delay[3] = 0;
		// long stall in the tail
		tab_words[4] = '{16'hdead, 16'hbeef, 16'h0, 16'h1111};
		tab_stall[4] = 5;
		tab_len[4] = 2 * int'(TX_TIMEOUT);
		tab_delay[4] = 5;
	endtask

	// --------------------
	// payload source
	// --------------------
	always @(posedge clk_sys) begin
		if (rst_n) begin
			if (ready_check) begin
				assert (!payload_ready)
					else begin
						$display("Fail payload_ready: got %h expected %h", payload_ready, 1'b0);
						errors++;
					end
				ready_check = 0;
			end
			if (payload_valid && payload_ready) begin
				payload_valid <= 1'b0;
				pay_idx++;
				pay_wait = 0;
				ready_check = 1;
			end else if (payload_ready && !payload_valid) begin
				assert (pay_idx < 4)
					else begin
						$display("payload sender asked for more words than a frame holds");
						errors++;
					end
				if (pay_wait >= pay_delay) begin
					payload_valid <= 1'b1;
					payload_word <= pay_words[pay_idx % 4];
				end else begin
					pay_wait++;
				end
			end
		end
	end

	// --------------------
	// serial decoder and cts control
	// --------------------
	always @(posedge clk_sys) begin
		if (cts_hold > 0) begin
			cts_hold--;
			if (cts_hold == 0)
				cts <= 1'b1;
		end
		if (rst_n) begin
			case (dec_state)
				0: begin
					if (!tx_line) begin
						dec_state = 1;
						dec_bits = 0;
					end
				end
				1: begin
					dec_shift = {dec_shift[14:0], tx_line};
					dec_bits++;
					if (dec_bits == 16)
						dec_state = 2;
				end
				default: begin
					assert (tx_line)
						else begin
							$display("stop bit missing after word %0d", dec_count);
							errors++;
						end
					rx_words.push_back(dec_shift);
					// drop cts during the stop bit of word k
					if (dec_count == stall_k) begin
						cts <= 1'b0;
						cts_hold = stall_len;
					end
					dec_count++;
					dec_state = 0;
				end
			endcase
		end
	end

	always @(posedge clk_sys) begin
		if (frame_done)
			done_count++;
	end

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got == exp)
			else begin
				$display("Fail %s: got %h expected %h", name, got, exp);
				errors++;
			end
	endtask

	task automatic run_frame(input int row);
		logic [15:0] exp_words [$];
		logic [15:0] w;
		int exp_drop;
		exp_drop = 0;
		exp_words.push_back(HEAD_WORD);
		for (int i = 0; i < 4; i++) begin
			w = tab_words[row][i];
			if (w == 16'h0)
				random_word(w);
			pay_words[i] = w;
			exp_words.push_back(w);
		end
		for (int i = 0; i < int'(TAIL_WORDS); i++)
			exp_words.push_back(16'hffff);
		if (tab_stall[row] >= 0 && tab_len[row] > int'(TX_TIMEOUT)) begin
			exp_words.delete(tab_stall[row] + 1);
			exp_drop = 1;
		end
		stall_k = tab_stall[row];
		stall_len = tab_len[row];
		pay_delay = tab_delay[row];
		pay_idx = 0;
		pay_wait = 0;
		dec_count = 0;
		done_count = 0;
		rx_words.delete();

		@(posedge clk_sys) frame_start <= 1'b1;
		@(posedge clk_sys) frame_start <= 1'b0;
		@(posedge clk_sys);
		check_value("drop_cnt", 16'(drop_cnt), 16'h0);
		check_value("busy", 16'(busy), 16'h1);
		// a second request inside the frame must be ignored
		repeat (8) @(posedge clk_sys);
		frame_start <= 1'b1;
		@(posedge clk_sys) frame_start <= 1'b0;
		while (!frame_done)
			@(posedge clk_sys);
		repeat (4) @(posedge clk_sys);

		check_value("frame_done count", 16'(done_count), 16'h1);
		check_value("busy", 16'(busy), 16'h0);
		check_value("drop_cnt", 16'(drop_cnt), 16'(exp_drop));
		assert (rx_words.size() == exp_words.size())
			else begin
				$display("row %0d: %0d words on tx_line, %0d expected", row,
					rx_words.size(), exp_words.size());
				errors++;
			end
		for (int i = 0; i < exp_words.size() && i < rx_words.size(); i++)
			check_value("tx_line word", rx_words[i], exp_words[i]);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		clk_sys = 1'b0;
		rst_n = 1'b0;
		frame_start = 1'b0;
		payload_valid = 1'b0;
		payload_word = '0;
		cts = 1'b1;
		lfsr_q = 32'hb2f5;
		errors = 0;
		stall_k = -1;
		stall_len = 0;
		cts_hold = 0;
		dec_state = 0;
		dec_bits = 0;
		dec_count = 0;
		dec_shift = '0;
		pay_idx = 0;
		pay_wait = 0;
		pay_delay = 0;
		ready_check = 0;
		done_count = 0;
		load_table();
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(posedge clk_sys);
		check_value("tx_line", 16'(tx_line), 16'h1);
		check_value("busy", 16'(busy), 16'h0);
		check_value("payload_ready", 16'(payload_ready), 16'h0);
		check_value("drop_cnt", 16'(drop_cnt), 16'h0);
		for (int row = 0; row < N_ROWS; row++)
			run_frame(row);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCH_CYCLES) @(posedge clk_sys);
		$display("timeout, a frame did not complete in time");
		$display("errors: %0d", errors + 1);
		$display("Errors found");
		$finish;
	end

endmodule

// File: dv/commu_assertions.sv
// concurrent checks on the frame sequencer and serializer handshakes, bound into commu_top
`timescale 1ns/1ps

module commu_assertions (
	input logic clk_sys,
	input logic rst_n,
	input logic fire_head,
	input logic fire_data,
	input logic fire_tail,
	input logic word_fire_head,
	input logic word_fire_data,
	input logic word_fire_tail,
	input logic tx_fire,
	input logic tx_abort,
	input logic [1:0] st_tx,
	input logic tx_line
);
	import commu_pkg::*;

	// only one sender started or issuing a word at a time
	fire_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({fire_head, fire_data, fire_tail,
			word_fire_head, word_fire_data, word_fire_tail}))
		else $error("more than one sender fired in the same cycle");

	// idle serializer keeps the line high
	line_idle_high: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(st_tx == 2'd0) |-> tx_line)
		else $error("tx_line low while the serializer is idle");

	// abort lands exactly TX_TIMEOUT cycles into the wait of a fired word
	abort_on_timeout: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_abort |-> $past(tx_fire, int'(TX_TIMEOUT) + 1))
		else $error("tx_abort without a wait at the timeout");

endmodule

// File: source/commu_top.sv
// top of the framed word transmitter, wires the sequencer, the three senders and the serializer
`timescale 1ns/1ps

module commu_top (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic frame_start,
	output logic busy,
	output logic frame_done,
	input  logic payload_valid,
	output logic payload_ready,
	input  logic [commu_pkg::WORD_W-1:0] payload_word,
	input  logic cts,
	output logic tx_line,
	output logic [commu_pkg::CNT_W-1:0] drop_cnt
);
	import commu_pkg::*;

	// sender handshakes
	logic fire_head;
	logic fire_data;
	logic fire_tail;
	logic done_head;
	logic done_data;
	logic done_tail;

	// word handshakes
	logic word_fire_head;
	logic word_fire_data;
	logic word_fire_tail;
	logic [WORD_W-1:0] word_head;
	logic [WORD_W-1:0] word_data;
	logic [WORD_W-1:0] word_tail;
	logic word_done;

	// serializer side
	logic tx_fire;
	logic tx_abort;
	logic [WORD_W-1:0] tx_word;
	logic tx_done;

	commu_main u_main (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.frame_start(frame_start),
		.busy(busy),
		.frame_done(frame_done),
		.drop_cnt(drop_cnt),
		.fire_head(fire_head),
		.fire_data(fire_data),
		.fire_tail(fire_tail),
		.done_head(done_head),
		.done_data(done_data),
		.done_tail(done_tail),
		.word_fire_head(word_fire_head),
		.word_fire_data(word_fire_data),
		.word_fire_tail(word_fire_tail),
		.word_head(word_head),
		.word_data(word_data),
		.word_tail(word_tail),
		.word_done(word_done),
		.tx_fire(tx_fire),
		.tx_abort(tx_abort),
		.tx_word(tx_word),
		.tx_done(tx_done)
	);

	commu_head u_head (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.fire_head(fire_head),
		.done_head(done_head),
		.word_fire(word_fire_head),
		.word(word_head),
		.word_done(word_done)
	);

	commu_data u_data (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.fire_data(fire_data),
		.done_data(done_data),
		.payload_valid(payload_valid),
		.payload_ready(payload_ready),
		.payload_word(payload_word),
		.word_fire(word_fire_data),
		.word(word_data),
		.word_done(word_done)
	);

	commu_tail u_tail (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.fire_tail(fire_tail),
		.done_tail(done_tail),
		.word_fire(word_fire_tail),
		.word(word_tail),
		.word_done(word_done)
	);

	commu_tx u_tx (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.tx_fire(tx_fire),
		.tx_abort(tx_abort),
		.tx_word(tx_word),
		.tx_done(tx_done),
		.cts(cts),
		.tx_line(tx_line)
	);

endmodule

// File: source/commu_tx.sv
// serializer, sends one word as start bit, sixteen data bits MSB first and stop bit under cts
`timescale 1ns/1ps

module commu_tx (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic tx_fire,
	input  logic tx_abort,
	input  logic [commu_pkg::WORD_W-1:0] tx_word,
	output logic tx_done,
	input  logic cts,
	output logic tx_line
);
	import commu_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_HOLD = 2'd1;
	localparam logic [1:0] S_SEND = 2'd2;

	logic [1:0] st_tx;
	logic [4:0] bit_cnt;
	logic [WORD_W-1:0] shift_q;

	// --------------------
	// bit engine
	// --------------------
	// bit_cnt 0..15 shifts data, 16 puts the stop bit, 17 reports done
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_tx <= S_IDLE;
			bit_cnt <= '0;
			tx_line <= 1'b1;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			case (st_tx)
				S_IDLE: begin
					tx_line <= 1'b1;
					if (tx_fire) begin
						st_tx <= S_HOLD;
					end
				end
				S_HOLD: begin
					// abort wins over a cts rising in the same cycle
					if (tx_abort) begin
						st_tx <= S_IDLE;
					end else if (cts) begin
						st_tx <= S_SEND;
						tx_line <= 1'b0;
						bit_cnt <= '0;
					end
				end
				S_SEND: begin
					bit_cnt <= bit_cnt + 5'd1;
					if (bit_cnt < 5'(WORD_W)) begin
						tx_line <= shift_q[WORD_W-1];
					end else if (bit_cnt == 5'(WORD_W)) begin
						tx_line <= 1'b1;
					end else begin
						tx_done <= 1'b1;
						st_tx <= S_IDLE;
					end
				end
				default: st_tx <= S_IDLE;
			endcase
		end
	end

	// data shift register
	always_ff @(posedge clk_sys) begin
		if (st_tx == S_IDLE && tx_fire) begin
			shift_q <= tx_word;
		end else if (st_tx == S_SEND && bit_cnt < 5'(WORD_W)) begin
			shift_q <= {shift_q[WORD_W-2:0], 1'b0};
		end
	end

endmodule

// File: source/commu_main.sv
// frame sequencer, runs head, payload and tail senders in turn and times out stalled words
`timescale 1ns/1ps

module commu_main (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic frame_start,
	output logic busy,
	output logic frame_done,
	output logic [commu_pkg::CNT_W-1:0] drop_cnt,
	output logic fire_head,
	output logic fire_data,
	output logic fire_tail,
	input  logic done_head,
	input  logic done_data,
	input  logic done_tail,
	input  logic word_fire_head,
	input  logic word_fire_data,
	input  logic word_fire_tail,
	input  logic [commu_pkg::WORD_W-1:0] word_head,
	input  logic [commu_pkg::WORD_W-1:0] word_data,
	input  logic [commu_pkg::WORD_W-1:0] word_tail,
	output logic word_done,
	output logic tx_fire,
	output logic tx_abort,
	output logic [commu_pkg::WORD_W-1:0] tx_word,
	input  logic tx_done
);
	import commu_pkg::*;

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_HEAD = 3'd1;
	localparam logic [2:0] S_DATA = 3'd2;
	localparam logic [2:0] S_TAIL = 3'd3;
	localparam logic [2:0] S_DONE = 3'd4;

	logic [2:0] st_frame;
	logic word_pend;
	logic [15:0] cnt_wait;
	logic word_drop;

	// --------------------
	// frame FSM
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_frame <= S_IDLE;
			fire_head <= 1'b0;
			fire_data <= 1'b0;
			fire_tail <= 1'b0;
		end else begin
			fire_head <= 1'b0;
			fire_data <= 1'b0;
			fire_tail <= 1'b0;
			case (st_frame)
				S_IDLE: begin
					if (frame_start) begin
						st_frame <= S_HEAD;
						fire_head <= 1'b1;
					end
				end
				S_HEAD: begin
					if (done_head) begin
						st_frame <= S_DATA;
						fire_data <= 1'b1;
					end
				end
				S_DATA: begin
					if (done_data) begin
						st_frame <= S_TAIL;
						fire_tail <= 1'b1;
					end
				end
				S_TAIL: st_frame <= done_tail ? S_DONE : S_TAIL;
				default: st_frame <= S_IDLE;
			endcase
		end
	end

	assign busy = (st_frame != S_IDLE);
	assign frame_done = (st_frame == S_DONE);

	// active sender drives the serializer
	always_comb begin
		case (st_frame)
			S_HEAD: begin
				tx_fire = word_fire_head;
				tx_word = word_head;
			end
			S_DATA: begin
				tx_fire = word_fire_data;
				tx_word = word_data;
			end
			S_TAIL: begin
				tx_fire = word_fire_tail;
				tx_word = word_tail;
			end
			default: begin
				tx_fire = 1'b0;
				tx_word = '0;
			end
		endcase
	end

	// --------------------
	// wait timeout
	// --------------------
	// abort is ignored once the word is on the line, so the word is
	// only taken as dropped when a word started just before the abort
	// would already have reported tx_done
	assign tx_abort = word_pend && !tx_done && (cnt_wait == TX_TIMEOUT);
	assign word_drop = word_pend && (cnt_wait == TX_TIMEOUT + 16'(WORD_W + 3));
	assign word_done = word_pend && (tx_done || word_drop);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			word_pend <= 1'b0;
			cnt_wait <= '0;
		end else if (tx_fire) begin
			word_pend <= 1'b1;
			cnt_wait <= '0;
		end else if (word_done) begin
			word_pend <= 1'b0;
			cnt_wait <= '0;
		end else if (word_pend) begin
			cnt_wait <= cnt_wait + 16'd1;
		end
	end

	// drops of the current or last frame
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			drop_cnt <= '0;
		end else if (frame_start && st_frame == S_IDLE) begin
			drop_cnt <= '0;
		end else if (word_drop) begin
			drop_cnt <= drop_cnt + 1'b1;
		end
	end

endmodule

// File: source/commu_tail.sv
// tail sender, issues TAIL_WORDS filler words to close a frame after fire_tail
`timescale 1ns/1ps

module commu_tail (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic fire_tail,
	output logic done_tail,
	output logic word_fire,
	output logic [commu_pkg::WORD_W-1:0] word,
	input  logic word_done
);
	import commu_pkg::*;

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_TAIL = 3'd1;
	localparam logic [2:0] S_FIRE = 3'd2;
	localparam logic [2:0] S_WAIT = 3'd3;
	localparam logic [2:0] S_NEXT = 3'd4;
	localparam logic [2:0] S_DONE = 3'd7;

	logic [2:0] st_tail;
	logic [CNT_W-1:0] cnt_tail;
	logic finish_tail;

	// --------------------
	// sender FSM
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_tail <= S_IDLE;
		end else begin
			case (st_tail)
				S_IDLE: st_tail <= fire_tail ? S_TAIL : S_IDLE;
				S_TAIL: st_tail <= S_FIRE;
				S_FIRE: st_tail <= S_WAIT;
				S_WAIT: st_tail <= word_done ? S_NEXT : S_WAIT;
				S_NEXT: st_tail <= finish_tail ? S_DONE : S_TAIL;
				default: st_tail <= S_IDLE;
			endcase
		end
	end

	// counts fillers as they are issued, cleared on the way out
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_tail <= '0;
		end else if (st_tail == S_TAIL) begin
			cnt_tail <= cnt_tail + 1'b1;
		end else if (st_tail == S_DONE) begin
			cnt_tail <= '0;
		end
	end

	assign finish_tail = (cnt_tail == TAIL_WORDS);

	// --------------------
	// outputs
	// --------------------
	assign done_tail = (st_tail == S_DONE);
	assign word_fire = (st_tail == S_FIRE);
	assign word = word_fire ? TAIL_WORD : '0;

endmodule

// File: source/commu_data.sv
// payload sender, pulls PAYLOAD_WORDS words from the valid/ready source and issues each one
`timescale 1ns/1ps

module commu_data (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic fire_data,
	output logic done_data,
	input  logic payload_valid,
	output logic payload_ready,
	input  logic [commu_pkg::WORD_W-1:0] payload_word,
	output logic word_fire,
	output logic [commu_pkg::WORD_W-1:0] word,
	input  logic word_done
);
	import commu_pkg::*;

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_FETCH = 3'd1;
	localparam logic [2:0] S_FIRE = 3'd2;
	localparam logic [2:0] S_WAIT = 3'd3;
	localparam logic [2:0] S_NEXT = 3'd4;
	localparam logic [2:0] S_DONE = 3'd5;

	logic [2:0] st_data;
	logic [CNT_W-1:0] cnt_data;
	logic [WORD_W-1:0] word_q;

	// --------------------
	// sender FSM
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_data <= S_IDLE;
		end else begin
			case (st_data)
				S_IDLE: st_data <= fire_data ? S_FETCH : S_IDLE;
				// no timeout here, the source is trusted to deliver
				S_FETCH: st_data <= payload_valid ? S_FIRE : S_FETCH;
				S_FIRE: st_data <= S_WAIT;
				S_WAIT: st_data <= word_done ? S_NEXT : S_WAIT;
				S_NEXT: st_data <= (cnt_data == PAYLOAD_WORDS) ? S_DONE : S_FETCH;
				default: st_data <= S_IDLE;
			endcase
		end
	end

	// words taken so far in this frame
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_data <= '0;
		end else if (st_data == S_FETCH && payload_valid) begin
			cnt_data <= cnt_data + 1'b1;
		end else if (st_data == S_DONE) begin
			cnt_data <= '0;
		end
	end

	// payload register, loaded on the transfer
	always_ff @(posedge clk_sys) begin
		if (st_data == S_FETCH && payload_valid) begin
			word_q <= payload_word;
		end
	end

	// --------------------
	// outputs
	// --------------------
	assign payload_ready = (st_data == S_FETCH);
	assign word_fire = (st_data == S_FIRE);
	assign word = word_q;
	assign done_data = (st_data == S_DONE);

endmodule

// File: source/commu_head.sv
// head sender, issues the single head word of a frame when commu_main pulses fire_head
`timescale 1ns/1ps

module commu_head (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic fire_head,
	output logic done_head,
	output logic word_fire,
	output logic [commu_pkg::WORD_W-1:0] word,
	input  logic word_done
);
	import commu_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_FIRE = 2'd1;
	localparam logic [1:0] S_WAIT = 2'd2;
	localparam logic [1:0] S_DONE = 2'd3;

	logic [1:0] st_head;

	// --------------------
	// sender FSM
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_head <= S_IDLE;
		end else begin
			case (st_head)
				S_IDLE: st_head <= fire_head ? S_FIRE : S_IDLE;
				S_FIRE: st_head <= S_WAIT;
				// sent or dropped, either way the word is resolved
				S_WAIT: st_head <= word_done ? S_DONE : S_WAIT;
				default: st_head <= S_IDLE;
			endcase
		end
	end

	// --------------------
	// outputs
	// --------------------
	assign done_head = (st_head == S_DONE);
	assign word_fire = (st_head == S_FIRE);

	// word only meaningful with word_fire
	assign word = word_fire ? HEAD_WORD : '0;

endmodule

// File: source/commu_pkg.sv
// frame constants of the serial word transmitter, imported by the RTL and the bound assertions
package commu_pkg;

	// --------------------
	// word format
	// --------------------
	localparam int WORD_W = 16;
	localparam int CNT_W = 8;

	// sync pattern that opens every frame
	localparam logic [WORD_W-1:0] HEAD_WORD = 16'heb90;
	// filler that closes a frame
	localparam logic [WORD_W-1:0] TAIL_WORD = 16'hffff;

	// --------------------
	// frame length
	// --------------------
	localparam logic [CNT_W-1:0] PAYLOAD_WORDS = 8'd4;
	localparam logic [CNT_W-1:0] TAIL_WORDS = 8'd3;

	// cycles a fired word may sit in front of a low cts
	localparam logic [15:0] TX_TIMEOUT = 16'd24;

endpackage
